// File: filelist.f
+incdir+tests
design/chess_pkg.sv
design/apb_pkg.sv
design/board_regs.sv
design/special_moves.sv
design/move_sequencer.sv
design/move_fifo.sv
design/special_move_top.sv
tests/move_gen_tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and pass only if the log holds the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module move_gen_tb
./obj_dir/Vmove_gen_tb | tee sim.log
grep -q "all tests passed" sim.log

// File: tests/apb_tasks.svh
`ifndef APB_TASKS_SVH
`define APB_TASKS_SVH

// setup and access phase of one transfer and back to an idle bus
task automatic apb_transfer(input logic is_write, input logic [7:0] addr,
	input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
	@(posedge clk);
	apb <= '{psel: 1'b1, penable: 1'b0, pwrite: is_write, paddr: addr, pwdata: wdata};
	@(posedge clk);
	apb.penable <= 1'b1;
	@(negedge clk);
	rdata = apb_rsp.prdata; // settled in the middle of the access cycle
	err = apb_rsp.pslverr;
	check_word($sformatf("pready on %h", addr), 32'h1, {31'd0, apb_rsp.pready});
	@(posedge clk);
	apb <= '0;
endtask

task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
	logic [31:0] rdata;
	logic err;
	apb_transfer(1'b1, addr, data, rdata, err);
	check_word($sformatf("pslverr on write %h", addr), 32'h0, {31'd0, err});
endtask

task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
	logic err;
	apb_transfer(1'b0, addr, 32'h0, data, err);
	check_word($sformatf("pslverr on read %h", addr), 32'h0, {31'd0, err});
endtask

// poll STATUS until done or until limit reads have gone by
task automatic wait_done(input int limit);
	logic [31:0] status;
	int polls;
	status = '0;
	polls = 0;
	while (!status[STATUS_DONE_BIT] && polls < limit) begin
		read_reg(STATUS_ADDR, status);
		polls++;
	end
	if (!status[STATUS_DONE_BIT]) begin
		$display("%s: done did not come up within %0d status reads", test_name, limit);
		errors++;
	end
endtask

`endif

// File: tests/move_gen_tb.sv
`timescale 1ns/1ps

module move_gen_tb import chess_pkg::*, apb_pkg::*; ();

	logic clk;
	logic reset;
	apb_req_t apb;
	apb_rsp_t apb_rsp;

	string test_name;
	int test_num = 0;
	int checks = 0;
	int errors = 0;
	int errors_before;
	integer seed = 59;
	move_t expected[$];
	board_t b;
	board_t castle_b;
	rights_t r;
	square_t blocker;
	square_t empty_sq;

	special_move_top dut (.clk(clk), .reset(reset), .apb(apb), .apb_rsp(apb_rsp));

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp)
		else begin
			$display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
			errors++;
		end
	endtask

	`include "apb_tasks.svh"

	task automatic begin_test(input string name);
		test_num++;
		test_name = name;
		errors_before = errors;
	endtask

	task automatic end_test();
		$display("test %0d %s: %s", test_num, test_name,
			errors == errors_before ? "ok" : "FAILED");
	endtask

	// slot order: kingside, queenside, then per file the pawn from the left and from the right
	function automatic void build_expected(input board_t bd, input rights_t rt);
		logic king_e1;
		expected.delete();
		king_e1 = bd[0][4] == W_KING;
		if (rt.castle_k && king_e1 && bd[0][5].piece == EMPTY && bd[0][6].piece == EMPTY
			&& bd[0][7] == W_ROOK)
			expected.push_back(move_t'({CASTLE_FLAGS, 3'd4, 3'd0, 3'd6, 3'd0}));
		if (rt.castle_q && king_e1 && bd[0][1].piece == EMPTY && bd[0][2].piece == EMPTY
			&& bd[0][3].piece == EMPTY && bd[0][0] == W_ROOK)
			expected.push_back(move_t'({CASTLE_FLAGS, 3'd4, 3'd0, 3'd2, 3'd0}));
		for (int f = 0; f < 8; f++) begin
			if (rt.enp[f] && f > 0)
				if (bd[4][f - 1] == W_PAWN)
					expected.push_back(move_t'({ENP_FLAGS, 3'(f - 1), 3'd4, 3'(f), 3'd5}));
			if (rt.enp[f] && f < 7)
				if (bd[4][f + 1] == W_PAWN)
					expected.push_back(move_t'({ENP_FLAGS, 3'(f + 1), 3'd4, 3'(f), 3'd5}));
		end
	endfunction

	task automatic random_position();
		logic [31:0] word;
		for (int k = 0; k < 8; k++)
			b[k] = rank_t'($random(seed));
		// ranks 1 and 5 biased so special moves actually show up
		for (int f = 0; f < 8; f++) begin
			b[RANK_1][f] = ($random(seed) % 4 == 0) ? blocker : empty_sq;
			b[RANK_5][f] = ($random(seed) % 2 == 0) ? W_PAWN : blocker;
		end
		b[RANK_1][FILE_A] = ($random(seed) % 4 == 0) ? blocker : W_ROOK;
		b[RANK_1][FILE_E] = ($random(seed) % 4 == 0) ? blocker : W_KING;
		b[RANK_1][FILE_H] = ($random(seed) % 4 == 0) ? blocker : W_ROOK;
		word = $random(seed);
		r = word[$bits(rights_t)-1:0];
	endtask

	task automatic load_board(input board_t bd, input rights_t rt);
		for (int k = 0; k < 8; k++)
			write_reg(8'(4 * k), bd[k]);
		write_reg(RIGHTS_ADDR, {22'd0, rt});
	endtask

	// drain false reads only the first move and leaves the rest for the next start to flush
	task automatic compare_results(input bit drain);
		logic [31:0] word;
		logic [31:0] status_exp;
		wait_done(40);
		read_reg(STATUS_ADDR, word);
		status_exp = (32'(expected.size()) << STATUS_COUNT_LSB) | 32'h1;
		if (expected.size() == 0)
			status_exp |= 32'h1 << STATUS_EMPTY_BIT;
		check_word("status", status_exp, word);
		foreach (expected[i]) begin
			if (drain || i == 0) begin
				read_reg(MOVE_ADDR, word);
				check_word($sformatf("move %0d", i), {13'd0, expected[i]}, word);
			end
		end
		if (drain) begin
			read_reg(MOVE_ADDR, word);
			check_word("move after list", {13'd0, MOVE_INVALID}, word);
		end
	endtask

	task automatic run_and_compare(input bit drain);
		build_expected(b, r);
		load_board(b, r);
		write_reg(CTRL_ADDR, 32'h1);
		compare_results(drain);
	endtask

	initial begin
		logic [31:0] word;
		logic err;
		reset = 1'b1;
		apb = '0;
		blocker = '{color: 1'b1, piece: KNIGHT};
		empty_sq = '0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		begin_test("reset state");
		read_reg(STATUS_ADDR, word);
		check_word("status", 32'h2, word);
		read_reg(MOVE_ADDR, word);
		check_word("move when empty", {13'd0, MOVE_INVALID}, word);
		end_test();

		begin_test("castling both sides");
		b = '0;
		for (int f = 0; f < 8; f++) begin
			b[1][f] = W_PAWN;
			b[7][f] = blocker;
		end
		b[RANK_1][FILE_A] = W_ROOK;
		b[RANK_1][FILE_E] = W_KING;
		b[RANK_1][FILE_H] = W_ROOK;
		castle_b = b;
		r = '{castle_q: 1'b1, castle_k: 1'b1, enp: 8'h00};
		run_and_compare(1'b1);
		end_test();

		begin_test("castling blocked or disallowed");
		b[RANK_1][FILE_F] = blocker;
		run_and_compare(1'b1); // queenside left
		b[RANK_1][FILE_F] = empty_sq;
		r.castle_q = 1'b0;
		run_and_compare(1'b1); // kingside left
		b[RANK_1][FILE_F] = blocker;
		run_and_compare(1'b1);
		end_test();

		begin_test("en passant");
		b = '0;
		b[RANK_1][FILE_E] = W_KING;
		b[RANK_5][FILE_A] = W_PAWN;
		b[RANK_5][FILE_C] = W_PAWN;
		b[RANK_5][FILE_H] = W_PAWN;
		b[RANK_5][FILE_B] = '{color: 1'b1, piece: PAWN};
		b[RANK_5][FILE_G] = '{color: 1'b1, piece: PAWN};
		r = '{castle_q: 1'b0, castle_k: 1'b0, enp: 8'b0100_0010};
		run_and_compare(1'b1);
		r.enp = 8'b1100_0011; // edge files add nothing
		run_and_compare(1'b1);
		end_test();

		begin_test("random boards with restarts");
		for (int n = 0; n < 20; n++) begin
			random_position();
			run_and_compare(n % 2 == 1);
		end
		end_test();

		begin_test("bus errors and busy start");
		apb_transfer(1'b0, 8'h40, 32'h0, word, err);
		check_word("pslverr unmapped read", 32'h1, {31'd0, err});
		apb_transfer(1'b1, STATUS_ADDR, 32'h0, word, err);
		check_word("pslverr status write", 32'h1, {31'd0, err});
		b = castle_b;
		r = '{castle_q: 1'b1, castle_k: 1'b1, enp: 8'h00};
		build_expected(b, r);
		load_board(b, r);
		write_reg(CTRL_ADDR, 32'h1);
		write_reg(RANK0_ADDR, 32'h0); // king and rooks gone
		write_reg(CTRL_ADDR, 32'h1);
		compare_results(1'b1);
		end_test();

		$display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: design/special_move_top.sv
`timescale 1ns/1ps

module special_move_top import chess_pkg::*, apb_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  apb_req_t apb,
	output apb_rsp_t apb_rsp
);

	board_t board;
	rights_t rights;
	logic start;
	logic done;
	logic pop;
	move_list_t candidates;
	logic cand_valid;
	logic push;
	move_t push_move;
	move_t head;
	logic empty;
	logic full;
	logic [FIFO_AW:0] count;

	board_regs u_regs (
		.clk(clk), .reset(reset), .apb(apb), .apb_rsp(apb_rsp),
		.board(board), .rights(rights), .start(start), .done(done),
		.fifo_head(head), .fifo_empty(empty), .fifo_count(count), .pop(pop)
	);

	special_moves u_special (
		.clk(clk), .reset(reset), .start(start), .board(board), .rights(rights),
		.candidates(candidates), .cand_valid(cand_valid)
	);

	move_sequencer u_seq (
		.clk(clk), .reset(reset), .start(start), .cand_valid(cand_valid),
		.candidates(candidates), .full(full), .push(push), .push_move(push_move),
		.done(done)
	);

	// a new start throws away moves not read from the last run
	move_fifo u_fifo (
		.clk(clk), .reset(reset), .flush(start), .push(push), .push_move(push_move),
		.pop(pop), .head(head), .empty(empty), .full(full), .count(count)
	);

endmodule

// File: design/move_fifo.sv
`timescale 1ns/1ps

module move_fifo import chess_pkg::*; (
	input  logic             clk,
	input  logic             reset,
	input  logic             flush,
	input  logic             push,
	input  move_t            push_move,
	input  logic             pop,
	output move_t            head,
	output logic             empty,
	output logic             full,
	output logic [FIFO_AW:0] count
);

	move_t mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic do_push;
	logic do_pop;

	assign empty = count == '0;
	assign full = count == (FIFO_AW + 1)'(FIFO_DEPTH);
	assign do_push = push & ~full;
	assign do_pop = pop & ~empty; // pop on empty is dropped
	assign head = empty ? MOVE_INVALID : mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // wraps at depth
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_move;
	end

endmodule

// File: design/move_sequencer.sv
`timescale 1ns/1ps

module move_sequencer import chess_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       start,
	input  logic       cand_valid,
	input  move_list_t candidates,
	input  logic       full,
	output logic       push,
	output move_t      push_move,
	output logic       done
);

	logic running;
	logic done_q;
	logic [SLOT_W-1:0] idx;
	logic advance;
	logic last;

	assign push_move = candidates[idx];
	assign push = running & ~push_move.flags.invalid & ~full;

	// an invalid slot is skipped even when the FIFO is full
	assign advance = running & ~(full & ~push_move.flags.invalid);
	assign last = idx == SLOT_W'(NUM_SLOTS - 1);

	// high in the cycle the last slot goes, then held
	assign done = done_q | (advance & last);

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			done_q <= 1'b0;
			idx <= '0;
		end else if (start) begin
			running <= 1'b0;
			done_q <= 1'b0;
		end else if (cand_valid) begin
			running <= 1'b1;
			idx <= '0;
		end else if (advance) begin
			if (last) begin
				running <= 1'b0;
				done_q <= 1'b1;
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

endmodule

// File: design/special_moves.sv
`timescale 1ns/1ps

module special_moves import chess_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       start,
	input  board_t     board,
	input  rights_t    rights,
	output move_list_t candidates,
	output logic       cand_valid
);

	move_list_t cand_next;
	logic castle_k_ok;
	logic castle_q_ok;

	function automatic move_t make_move(
		input move_flags_t flags,
		input int          from_file,
		input int          from_rank,
		input int          to_file,
		input int          to_rank
	);
		move_t m;
		m.flags = flags;
		m.from.file = 3'(from_file);
		m.from.rank = 3'(from_rank);
		m.to.file = 3'(to_file);
		m.to.rank = 3'(to_rank);
		return m;
	endfunction

	// check and attacked squares are not looked at
	assign castle_k_ok = rights.castle_k
		&& board[RANK_1][FILE_E] == W_KING
		&& board[RANK_1][FILE_F].piece == EMPTY
		&& board[RANK_1][FILE_G].piece == EMPTY
		&& board[RANK_1][FILE_H] == W_ROOK;

	assign castle_q_ok = rights.castle_q
		&& board[RANK_1][FILE_E] == W_KING
		&& board[RANK_1][FILE_D].piece == EMPTY
		&& board[RANK_1][FILE_C].piece == EMPTY
		&& board[RANK_1][FILE_B].piece == EMPTY
		&& board[RANK_1][FILE_A] == W_ROOK;

	always_comb begin
		for (int s = 0; s < NUM_SLOTS; s++)
			cand_next[s] = MOVE_INVALID;

		if (castle_k_ok)
			cand_next[SLOT_CASTLE_K] = make_move(CASTLE_FLAGS, FILE_E, RANK_1, FILE_G, RANK_1);
		if (castle_q_ok)
			cand_next[SLOT_CASTLE_Q] = make_move(CASTLE_FLAGS, FILE_E, RANK_1, FILE_C, RANK_1);

		// capturing pawn from the left, nothing left of file a
		for (int f = FILE_B; f <= FILE_H; f++) begin
			if (rights.enp[f] && board[RANK_5][f - 1] == W_PAWN)
				cand_next[SLOT_ENP + 2 * f] = make_move(ENP_FLAGS, f - 1, RANK_5, f, RANK_6);
		end

		// from the right, nothing right of file h
		for (int f = FILE_A; f < FILE_H; f++) begin
			if (rights.enp[f] && board[RANK_5][f + 1] == W_PAWN)
				cand_next[SLOT_ENP + 2 * f + 1] = make_move(ENP_FLAGS, f + 1, RANK_5, f, RANK_6);
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			cand_valid <= 1'b0;
		else
			cand_valid <= start;
	end

	always_ff @(posedge clk) begin
		if (start)
			candidates <= cand_next;
	end

endmodule

// File: design/board_regs.sv
`timescale 1ns/1ps

module board_regs import chess_pkg::*, apb_pkg::*; (
	input  logic             clk,
	input  logic             reset,
	input  apb_req_t         apb,
	output apb_rsp_t         apb_rsp,
	output board_t           board,
	output rights_t          rights,
	output logic             start,
	input  logic             done,
	input  move_t            fifo_head,
	input  logic             fifo_empty,
	input  logic [FIFO_AW:0] fifo_count,
	output logic             pop
);

	logic access;
	logic wr;
	logic rd;
	logic [2:0] rank_idx;
	logic rank_sel;
	logic ctrl_sel;
	logic rights_sel;
	logic status_sel;
	logic move_sel;
	logic mapped;
	logic busy; // a run is in progress

	assign access = apb.psel & apb.penable;
	assign wr = access & apb.pwrite;
	assign rd = access & ~apb.pwrite;
	assign rank_idx = apb.paddr[4:2];

	always_comb begin
		rank_sel = 1'b0;
		ctrl_sel = 1'b0;
		rights_sel = 1'b0;
		status_sel = 1'b0;
		move_sel = 1'b0;
		case (apb.paddr)
			RANK0_ADDR, RANK1_ADDR, RANK2_ADDR, RANK3_ADDR,
			RANK4_ADDR, RANK5_ADDR, RANK6_ADDR, RANK7_ADDR: rank_sel = 1'b1;
			CTRL_ADDR: ctrl_sel = 1'b1;
			RIGHTS_ADDR: rights_sel = 1'b1;
			STATUS_ADDR: status_sel = 1'b1;
			MOVE_ADDR: move_sel = 1'b1;
			default: rank_sel = 1'b0;
		endcase
	end

	assign mapped = rank_sel | ctrl_sel | rights_sel | status_sel | move_sel;

	always_ff @(posedge clk) begin
		if (reset) begin
			board <= '0;
			rights <= '0;
			start <= 1'b0;
			busy <= 1'b0;
		end else begin
			start <= 1'b0;
			if (wr && rank_sel)
				board[rank_idx] <= rank_t'(apb.pwdata);
			if (wr && rights_sel)
				rights <= rights_t'(apb.pwdata[$bits(rights_t)-1:0]);
			if (wr && ctrl_sel && apb.pwdata[CTRL_START_BIT] && !busy) begin
				start <= 1'b1;
				busy <= 1'b1;
			end else if (done && !start) begin
				busy <= 1'b0; // done of the old run is still up while start is
			end
		end
	end

	// head leaves on the same access cycle that returns it
	assign pop = rd & move_sel & ~fifo_empty;

	always_comb begin
		apb_rsp.pready = 1'b1;
		apb_rsp.pslverr = access & (~mapped | (apb.pwrite & (status_sel | move_sel))
			| (~apb.pwrite & ctrl_sel));
		apb_rsp.prdata = '0;
		if (rank_sel)
			apb_rsp.prdata = board[rank_idx];
		else if (rights_sel)
			apb_rsp.prdata[$bits(rights_t)-1:0] = rights;
		else if (status_sel) begin
			apb_rsp.prdata[STATUS_DONE_BIT] = done;
			apb_rsp.prdata[STATUS_EMPTY_BIT] = fifo_empty;
			apb_rsp.prdata[STATUS_COUNT_LSB +: FIFO_AW + 1] = fifo_count;
		end else if (move_sel)
			apb_rsp.prdata[$bits(move_t)-1:0] = fifo_head; // invalid word when empty
	end

endmodule

// File: design/apb_pkg.sv
package apb_pkg;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	localparam logic [7:0] RANK0_ADDR = 8'h00;
	localparam logic [7:0] RANK1_ADDR = 8'h04;
	localparam logic [7:0] RANK2_ADDR = 8'h08;
	localparam logic [7:0] RANK3_ADDR = 8'h0C;
	localparam logic [7:0] RANK4_ADDR = 8'h10;
	localparam logic [7:0] RANK5_ADDR = 8'h14;
	localparam logic [7:0] RANK6_ADDR = 8'h18;
	localparam logic [7:0] RANK7_ADDR = 8'h1C;
	localparam logic [7:0] CTRL_ADDR   = 8'h20;
	localparam logic [7:0] RIGHTS_ADDR = 8'h24;
	localparam logic [7:0] STATUS_ADDR = 8'h28;
	localparam logic [7:0] MOVE_ADDR   = 8'h2C;

	localparam int CTRL_START_BIT   = 0;
	localparam int STATUS_DONE_BIT  = 0;
	localparam int STATUS_EMPTY_BIT = 1;
	localparam int STATUS_COUNT_LSB = 8;

endpackage

// File: design/chess_pkg.sv
package chess_pkg;

	typedef enum logic [2:0] {
		EMPTY  = 3'o0,
		PAWN   = 3'o1,
		KNIGHT = 3'o2,
		BISHOP = 3'o3,
		ROOK   = 3'o4,
		QUEEN  = 3'o5,
		KING   = 3'o6
	} piece_t;

	localparam logic WHITE = 1'b0;

	typedef struct packed {
		logic   color; // 0 is white
		piece_t piece;
	} square_t;

	typedef square_t [7:0] rank_t; // file a in the low nibble
	typedef rank_t [7:0] board_t;  // rank 1 in the low word

	localparam square_t W_KING = '{color: WHITE, piece: KING};
	localparam square_t W_ROOK = '{color: WHITE, piece: ROOK};
	localparam square_t W_PAWN = '{color: WHITE, piece: PAWN};

	localparam int FILE_A = 0;
	localparam int FILE_B = 1;
	localparam int FILE_C = 2;
	localparam int FILE_D = 3;
	localparam int FILE_E = 4;
	localparam int FILE_F = 5;
	localparam int FILE_G = 6;
	localparam int FILE_H = 7;
	localparam int RANK_1 = 0;
	localparam int RANK_5 = 4;
	localparam int RANK_6 = 5;

	typedef struct packed {
		logic [2:0] file;
		logic [2:0] rank;
	} coord_t;

	typedef struct packed {
		logic invalid;
		logic promote;
		logic pawn_move;
		logic pawn_two;
		logic en_passant;
		logic castle;
		logic capture;
	} move_flags_t;

	typedef struct packed {
		move_flags_t flags;
		coord_t      from;
		coord_t      to;
	} move_t;

	localparam move_t MOVE_INVALID = '{flags: '{invalid: 1'b1, default: 1'b0},
		from: '0, to: '0};
	localparam move_flags_t CASTLE_FLAGS = '{castle: 1'b1, default: 1'b0};
	localparam move_flags_t ENP_FLAGS = '{pawn_move: 1'b1, en_passant: 1'b1, capture: 1'b1,
		default: 1'b0};

	typedef struct packed {
		logic       castle_q;
		logic       castle_k;
		logic [7:0] enp; // bit n is file n, pawn there just moved two squares
	} rights_t;

	localparam int NUM_SLOTS = 18;
	localparam int SLOT_W = $clog2(NUM_SLOTS);
	localparam int SLOT_CASTLE_K = 0;
	localparam int SLOT_CASTLE_Q = 1;
	localparam int SLOT_ENP = 2; // two slots per file from here

	typedef move_t [NUM_SLOTS-1:0] move_list_t;

	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);

endpackage
